//--- src/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8;

	// low address bits that select a byte inside one data word
	localparam int addr_lsb = $clog2(strb_w);

	typedef enum logic [1:0] {
		resp_okay   = 2'd0,
		resp_slverr = 2'd2
	} resp_t;

endpackage

`default_nettype wire

//--- src/sram_cfg_pkg.sv
`default_nettype none

package sram_cfg_pkg;

	localparam int mem_depth = 256;
	localparam int idx_w = $clog2(mem_depth);

	// response stall counts run from 0 to 7
	localparam int dly_w = 3;

	localparam logic [7:0] lfsr_seed = 8'h5a;
	// x^8 + x^6 + x^5 + x^4 + 1, right-shifting Galois form
	localparam logic [7:0] lfsr_taps = 8'hb8;

endpackage

`default_nettype wire

//--- src/stall_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

module stall_lfsr (
	input  wire logic       clk,
	input  wire logic       reset,
	output logic      [7:0] random
);

	logic [7:0] state;

	// the seed is nonzero, so the all-zero lock-up state is never reached
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sram_cfg_pkg::lfsr_seed;
		end else if (state[0]) begin
			state <= {1'b0, state[7:1]} ^ sram_cfg_pkg::lfsr_taps;
		end else begin
			state <= {1'b0, state[7:1]};
		end
	end

	assign random = state;

endmodule

`default_nettype wire

//--- src/resp_delay.sv
`timescale 1ns/1ns
`default_nettype none

module resp_delay (
	input  wire logic                           clk,
	input  wire logic                           reset,
	input  wire logic                           level_in,
	input  wire logic [sram_cfg_pkg::dly_w-1:0] count,
	output logic                                level_out
);

	logic [sram_cfg_pkg::dly_w-1:0] cnt;
	logic                           done;

	// keep sampling a fresh count while idle, so each response gets its own stall
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt  <= '0;
			done <= 1'b0;
		end else if (!level_in) begin
			cnt  <= count;
			done <= 1'b0;
		end else if (cnt == '0) begin
			done <= 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// falls in the same cycle as the input, which lets pending and valid drop together
	assign level_out = level_in & done;

endmodule

`default_nettype wire

//--- src/mem_array.sv
`timescale 1ns/1ns
`default_nettype none

module mem_array (
	input  wire logic                              clk,
	input  wire logic [sram_cfg_pkg::idx_w-1:0]    rd_idx,
	output logic      [axi_lite_pkg::data_w-1:0]   rd_data,
	input  wire logic                              wr_en,
	input  wire logic [sram_cfg_pkg::idx_w-1:0]    wr_idx,
	input  wire logic [axi_lite_pkg::data_w-1:0]   wr_data,
	input  wire logic [axi_lite_pkg::strb_w-1:0]   wr_strb
);

	logic [axi_lite_pkg::data_w-1:0] mem [sram_cfg_pkg::mem_depth];

	assign rd_data = mem[rd_idx];

	// only the bytes whose strobe bit is set are updated
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < axi_lite_pkg::strb_w; b++) begin
				if (wr_strb[b]) begin
					mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/sram.sv
`timescale 1ns/1ns
`default_nettype none

module sram (
	input  wire logic                                   clk,
	input  wire logic                                   reset,

	input  wire logic [axi_lite_pkg::addr_w-1:0]        araddr,
	input  wire logic                                   arvalid,
	output logic                                        arready,

	output logic      [axi_lite_pkg::data_w-1:0]        rdata,
	output axi_lite_pkg::resp_t                         rresp,
	output logic                                        rvalid,
	input  wire logic                                   rready,

	input  wire logic [axi_lite_pkg::addr_w-1:0]        awaddr,
	input  wire logic                                   awvalid,
	output logic                                        awready,

	input  wire logic [axi_lite_pkg::data_w-1:0]        wdata,
	input  wire logic [axi_lite_pkg::strb_w-1:0]        wstrb,
	input  wire logic                                   wvalid,
	output logic                                        wready,

	output axi_lite_pkg::resp_t                         bresp,
	output logic                                        bvalid,
	input  wire logic                                   bready,

	input  wire logic [7:0]                             random,

	output logic      [sram_cfg_pkg::idx_w-1:0]         mem_rd_idx,
	input  wire logic [axi_lite_pkg::data_w-1:0]        mem_rd_data,
	output logic                                        mem_wr_en,
	output logic      [sram_cfg_pkg::idx_w-1:0]         mem_wr_idx,
	output logic      [axi_lite_pkg::data_w-1:0]        mem_wr_data,
	output logic      [axi_lite_pkg::strb_w-1:0]        mem_wr_strb
);

	localparam int lsb = axi_lite_pkg::addr_lsb;

	logic ar_pending;
	logic aw_pending;
	logic w_pending;
	logic ar_in_range;
	logic aw_in_range;

	logic [axi_lite_pkg::addr_w-1:0] stored_awaddr;
	logic [axi_lite_pkg::data_w-1:0] stored_wdata;
	logic [axi_lite_pkg::strb_w-1:0] stored_wstrb;

	// an address is valid when its word index falls below the configured depth
	assign ar_in_range = araddr[axi_lite_pkg::addr_w-1:lsb] < sram_cfg_pkg::mem_depth;
	assign aw_in_range = stored_awaddr[axi_lite_pkg::addr_w-1:lsb] < sram_cfg_pkg::mem_depth;

	assign mem_rd_idx = araddr[sram_cfg_pkg::idx_w+lsb-1:lsb];

	always_ff @(posedge clk) begin
		if (reset) begin
			rdata <= '0;
			rresp <= axi_lite_pkg::resp_okay;
		end else if (arvalid && arready) begin
			rdata <= ar_in_range ? mem_rd_data : '0;
			rresp <= ar_in_range ? axi_lite_pkg::resp_okay : axi_lite_pkg::resp_slverr;
		end
	end

	// read side holds one transaction from the AR handshake to the R handshake
	always_ff @(posedge clk) begin
		if (reset) begin
			ar_pending <= 1'b0;
			arready    <= 1'b1;
		end else begin
			ar_pending <= (!ar_pending && arvalid && arready) ||
				(ar_pending && !(rvalid && rready));
			arready    <= (!arready && rvalid && rready) || (arready && !arvalid);
		end
	end

	resp_delay rvalid_delay (
		.clk       (clk),
		.reset     (reset),
		.level_in  (ar_pending),
		.count     (random[3:1]),
		.level_out (rvalid)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			aw_pending <= 1'b0;
			awready    <= 1'b1;
			w_pending  <= 1'b0;
			wready     <= 1'b1;
		end else begin
			aw_pending <= (!aw_pending && awvalid && awready) ||
				(aw_pending && !(bvalid && bready));
			awready    <= (bvalid && bready) || (awready && !awvalid);
			w_pending  <= (!w_pending && wvalid && wready) ||
				(w_pending && !(bvalid && bready));
			wready     <= (bvalid && bready) || (wready && !wvalid);
		end
	end

	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			stored_awaddr <= awaddr;
		end
		if (wvalid && wready) begin
			stored_wdata <= wdata;
			stored_wstrb <= wstrb;
		end
	end

	// the response stall only starts once address and data have both arrived
	resp_delay bvalid_delay (
		.clk       (clk),
		.reset     (reset),
		.level_in  (aw_pending && w_pending),
		.count     (random[2:0]),
		.level_out (bvalid)
	);

	assign bresp = aw_in_range ? axi_lite_pkg::resp_okay : axi_lite_pkg::resp_slverr;

	// memory is written in the B handshake cycle, never for an out-of-range address
	assign mem_wr_en   = bvalid && bready && aw_in_range;
	assign mem_wr_idx  = stored_awaddr[sram_cfg_pkg::idx_w+lsb-1:lsb];
	assign mem_wr_data = stored_wdata;
	assign mem_wr_strb = stored_wstrb;

endmodule

`default_nettype wire

//--- src/sram_top.sv
`timescale 1ns/1ns
`default_nettype none

module sram_top (
	input  wire logic                              clk,
	input  wire logic                              reset,

	input  wire logic [axi_lite_pkg::addr_w-1:0]   araddr,
	input  wire logic                              arvalid,
	output logic                                   arready,

	output logic      [axi_lite_pkg::data_w-1:0]   rdata,
	output axi_lite_pkg::resp_t                    rresp,
	output logic                                   rvalid,
	input  wire logic                              rready,

	input  wire logic [axi_lite_pkg::addr_w-1:0]   awaddr,
	input  wire logic                              awvalid,
	output logic                                   awready,

	input  wire logic [axi_lite_pkg::data_w-1:0]   wdata,
	input  wire logic [axi_lite_pkg::strb_w-1:0]   wstrb,
	input  wire logic                              wvalid,
	output logic                                   wready,

	output axi_lite_pkg::resp_t                    bresp,
	output logic                                   bvalid,
	input  wire logic                              bready
);

	logic [7:0]                        random;
	logic [sram_cfg_pkg::idx_w-1:0]    mem_rd_idx;
	logic [axi_lite_pkg::data_w-1:0]   mem_rd_data;
	logic                              mem_wr_en;
	logic [sram_cfg_pkg::idx_w-1:0]    mem_wr_idx;
	logic [axi_lite_pkg::data_w-1:0]   mem_wr_data;
	logic [axi_lite_pkg::strb_w-1:0]   mem_wr_strb;

	stall_lfsr stall_lfsr_i (
		.clk    (clk),
		.reset  (reset),
		.random (random)
	);

	sram sram_i (
		.clk         (clk),
		.reset       (reset),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.random      (random),
		.mem_rd_idx  (mem_rd_idx),
		.mem_rd_data (mem_rd_data),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_idx  (mem_wr_idx),
		.mem_wr_data (mem_wr_data),
		.mem_wr_strb (mem_wr_strb)
	);

	mem_array mem_array_i (
		.clk     (clk),
		.rd_idx  (mem_rd_idx),
		.rd_data (mem_rd_data),
		.wr_en   (mem_wr_en),
		.wr_idx  (mem_wr_idx),
		.wr_data (mem_wr_data),
		.wr_strb (mem_wr_strb)
	);

endmodule

`default_nettype wire

//--- tests/sram_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sram_tb;

	localparam int clk_period = 10;
	// longest stall plus an allowance for random back-pressure
	localparam int worst_cycles = 9 + 32;

	logic                              clk;
	logic                              reset;
	logic [axi_lite_pkg::addr_w-1:0]   araddr;
	logic                              arvalid;
	logic                              arready;
	logic [axi_lite_pkg::data_w-1:0]   rdata;
	axi_lite_pkg::resp_t               rresp;
	logic                              rvalid;
	logic                              rready;
	logic [axi_lite_pkg::addr_w-1:0]   awaddr;
	logic                              awvalid;
	logic                              awready;
	logic [axi_lite_pkg::data_w-1:0]   wdata;
	logic [axi_lite_pkg::strb_w-1:0]   wstrb;
	logic                              wvalid;
	logic                              wready;
	axi_lite_pkg::resp_t               bresp;
	logic                              bvalid;
	logic                              bready;

	int                                vec_test[$];
	logic [7:0]                        vec_op[$];
	logic [axi_lite_pkg::addr_w-1:0]   vec_addr[$];
	logic [axi_lite_pkg::data_w-1:0]   vec_data[$];
	logic [axi_lite_pkg::strb_w-1:0]   vec_strb[$];
	axi_lite_pkg::resp_t               vec_resp[$];

	logic [31:0] rng_state;
	logic        loaded;
	int          pass_count;
	int          fail_count;
	int          test_errs;

	sram_top sram_top_i (
		.clk     (clk),
		.reset   (reset),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic coin();
		logic [31:0] r;
		r = next_rand();
		return r[0];
	endfunction

	task automatic check_word(input logic [axi_lite_pkg::data_w-1:0] got, exp,
			input string what);
		if (got !== exp) begin
			$display("Fail %0t: %s data %h, expected %h", $time, what, got, exp);
			fail_count++;
			test_errs++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_resp(input axi_lite_pkg::resp_t got, exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t: %s resp %0d, expected %0d", $time, what, got, exp);
			fail_count++;
			test_errs++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_level(input logic got, exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
			fail_count++;
			test_errs++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic load_vectors();
		int                              fd;
		int                              n;
		int                              t;
		string                           line;
		logic [7:0]                      op;
		logic [axi_lite_pkg::addr_w-1:0] a;
		logic [axi_lite_pkg::data_w-1:0] d;
		logic [axi_lite_pkg::strb_w-1:0] s;
		logic [1:0]                      r;
		fd = $fopen("tests/sram_golden.txt", "r");
		if (fd == 0) begin
			$display("golden file tests/sram_golden.txt could not be opened");
			fail_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 2 && line.getc(0) != "#") begin
					n = $sscanf(line, "%d %s %h %h %h %h", t, op, a, d, s, r);
					if (n == 6) begin
						vec_test.push_back(t);
						vec_op.push_back(op);
						vec_addr.push_back(a);
						vec_data.push_back(d);
						vec_strb.push_back(s);
						vec_resp.push_back(axi_lite_pkg::resp_t'(r));
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic do_read(input int i);
		logic [axi_lite_pkg::data_w-1:0] held_data;
		axi_lite_pkg::resp_t             held_resp;
		logic                            seen;
		logic                            done;
		string                           what;
		what = $sformatf("test %0d read %h", vec_test[i], vec_addr[i]);
		@(negedge clk);
		araddr = vec_addr[i];
		arvalid = 1'b1;
		while (!arready) @(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		seen = 1'b0;
		done = 1'b0;
		// the response must hold still for as long as rready stays low
		while (!done) begin
			rready = coin();
			if (rvalid) begin
				if (seen) begin
					check_word(rdata, held_data, {what, " under stall"});
					check_resp(rresp, held_resp, {what, " under stall"});
				end
				held_data = rdata;
				held_resp = rresp;
				seen = 1'b1;
				check_level(arready, 1'b0, {what, " arready"});
				done = rready;
			end else if (seen) begin
				check_level(rvalid, 1'b1, {what, " rvalid under stall"});
				done = 1'b1;
			end
			@(negedge clk);
		end
		rready = 1'b0;
		check_word(held_data, vec_data[i], what);
		check_resp(held_resp, vec_resp[i], what);
	endtask

	task automatic do_write(input int i);
		int                  order;
		int                  aw_at;
		int                  w_at;
		int                  cyc;
		logic                aw_done;
		logic                w_done;
		logic                aw_go;
		logic                w_go;
		logic                seen;
		logic                done;
		axi_lite_pkg::resp_t held_resp;
		string               what;
		what = $sformatf("test %0d write %h", vec_test[i], vec_addr[i]);
		// 0 presents AW first, 1 presents W first, 2 presents both together
		order = int'(next_rand() % 3);
		aw_at = (order == 1) ? 3 : 0;
		w_at = (order == 0) ? 3 : 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		aw_go = 1'b0;
		w_go = 1'b0;
		cyc = 0;
		awaddr = vec_addr[i];
		wdata = vec_data[i];
		wstrb = vec_strb[i];
		while (!(aw_done && w_done)) begin
			@(negedge clk);
			if (aw_go) begin
				awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_go) begin
				wvalid = 1'b0;
				w_done = 1'b1;
			end
			if (!aw_done && cyc >= aw_at) awvalid = 1'b1;
			if (!w_done && cyc >= w_at) wvalid = 1'b1;
			aw_go = awvalid && awready;
			w_go = wvalid && wready;
			cyc++;
		end
		seen = 1'b0;
		done = 1'b0;
		while (!done) begin
			bready = coin();
			if (bvalid) begin
				if (seen) check_resp(bresp, held_resp, {what, " under stall"});
				held_resp = bresp;
				seen = 1'b1;
				check_level(awready, 1'b0, {what, " awready"});
				check_level(wready, 1'b0, {what, " wready"});
				done = bready;
			end else if (seen) begin
				check_level(bvalid, 1'b1, {what, " bvalid under stall"});
				done = 1'b1;
			end
			@(negedge clk);
		end
		bready = 1'b0;
		check_resp(held_resp, vec_resp[i], what);
	endtask

	initial begin
		loaded = 1'b0;
		reset = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		rng_state = 32'hcfc7;
		pass_count = 0;
		fail_count = 0;
		test_errs = 0;
		load_vectors();
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_level(arready, 1'b1, "after reset arready");
		check_level(awready, 1'b1, "after reset awready");
		check_level(wready, 1'b1, "after reset wready");
		check_level(rvalid, 1'b0, "after reset rvalid");
		check_level(bvalid, 1'b0, "after reset bvalid");
		$display("test 0 finished with %0d errors", test_errs);
		test_errs = 0;
		for (int i = 0; i < vec_test.size(); i++) begin
			if (vec_op[i] == "W") begin
				do_write(i);
			end else begin
				do_read(i);
			end
			if (i == vec_test.size() - 1 || vec_test[i + 1] != vec_test[i]) begin
				$display("test %0d finished with %0d errors", vec_test[i], test_errs);
				test_errs = 0;
			end
		end
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		int limit;
		wait (loaded === 1'b1);
		limit = vec_test.size() * worst_cycles * clk_period + 2 * clk_period;
		#(limit);
		$display("timeout, the run was still going after %0d ns", limit);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- axi_sram.f
src/axi_lite_pkg.sv
src/sram_cfg_pkg.sv
src/stall_lfsr.sv
src/resp_delay.sv
src/mem_array.sv
src/sram.sv
src/sram_top.sv
tests/sram_tb.sv

//--- tests/sram_golden.txt
# test op addr data strb resp, all hex except the test number
# for R the data column is the expected rdata and strb is unused
1 W 00000000 11223344 f 0
1 R 00000000 11223344 0 0
1 W 000003fc deadbeef f 0
1 R 000003fc deadbeef 0 0
2 W 00000010 00000000 f 0
2 W 00000010 aabbccdd 1 0
2 R 00000010 000000dd 0 0
2 W 00000010 11223344 6 0
2 R 00000010 002233dd 0 0
2 W 00000010 99887766 8 0
2 R 00000010 992233dd 0 0
2 W 00000014 cafef00d f 0
2 W 00000014 12345678 5 0
2 R 00000014 ca34f078 0 0
2 W 00000014 ffffffff 0 0
2 R 00000014 ca34f078 0 0
3 W 00000400 ffffffff f 2
3 R 00000400 00000000 0 2
3 R 00000000 11223344 0 0
3 W 80000010 12345678 f 2
3 R 80000010 00000000 0 2
3 R 00000010 992233dd 0 0
4 W 00000020 01020304 f 0
4 W 00000024 05060708 f 0
4 R 00000020 01020304 0 0
4 R 00000024 05060708 0 0
4 W 00000020 ffffffff c 0
4 R 00000020 ffff0304 0 0
